//--- rf_pkg.sv
package rf_pkg;

    ////////////////////////////////////////////////////////////
    // Widths and address map
    ////////////////////////////////////////////////////////////
    localparam int DATA_W       = 16;
    localparam int ADDR_W       = 5;
    localparam int NUM_REGS     = 32;

    localparam int FLAGS_ADDR   = 22;
    localparam int RO_ADDR      = 23;
    localparam int VERTEX_BASE  = 24;
    localparam int NUM_VERTEX   = 8;
    localparam int NUM_KEYS     = 5;

    // Return object plus the vertex registers
    localparam int NUM_VPU_REGS = NUM_VERTEX + 1;

    // General-purpose byte at the top of the flags word
    localparam int GEN_W        = DATA_W - NUM_KEYS - 3;

    typedef logic [DATA_W-1:0]   word_t;
    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [NUM_REGS-1:0] reg_vec_t;

    ////////////////////////////////////////////////////////////
    // Port groups
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic  we;
        addr_t addr;
        word_t data;
    } cpu_wr_t;

    typedef struct packed {
        logic z;
        logic n;
        logic v;
    } cpu_flags_t;

    // Bulk write from the VPU, all nine registers in one cycle
    typedef struct packed {
        logic                       we;
        word_t                      ret_obj;
        word_t [NUM_VERTEX-1:0]     vertex;
    } vpu_wr_t;

    typedef struct packed {
        word_t                      ret_obj;
        word_t [NUM_VERTEX-1:0]     vertex;
    } vpu_rd_t;

    ////////////////////////////////////////////////////////////
    // Flags word layout
    ////////////////////////////////////////////////////////////
    // Key bits: 3 up, 2 down, 1 left, 0 right, 4 spare
    typedef struct packed {
        logic [GEN_W-1:0]    general;
        logic [NUM_KEYS-1:0] keys;
        logic                z;
        logic                n;
        logic                v;
    } flags_fields_t;

    typedef union packed {
        word_t         raw;
        flags_fields_t fields;
    } flags_word_u;

endpackage

//--- cpu_write_decode.sv
`timescale 1ns/1ps

module cpu_write_decode (
    input  rf_pkg::cpu_wr_t  wr_a,
    input  rf_pkg::cpu_wr_t  wr_b,
    output rf_pkg::reg_vec_t cpu_we,
    output rf_pkg::reg_vec_t take_b
);

    import rf_pkg::*;

    // One-hot target of each port, zero when the port is idle
    reg_vec_t hit_a;
    reg_vec_t hit_b;

    ////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < NUM_REGS; i++) begin
            hit_a[i] = wr_a.we && (wr_a.addr == addr_t'(i));
            hit_b[i] = wr_b.we && (wr_b.addr == addr_t'(i));
        end
    end

    ////////////////////////////////////////////////////////////
    // Merge and collision resolution
    ////////////////////////////////////////////////////////////
    // Any port hitting a register enables it
    assign cpu_we = hit_a | hit_b;

    // Port B data only where port A is not writing the same register
    assign take_b = hit_b & ~hit_a;

endmodule

//--- gp_reg_bank.sv
`timescale 1ns/1ps

module gp_reg_bank (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic [rf_pkg::FLAGS_ADDR-1:0]            cpu_we,
    input  logic [rf_pkg::FLAGS_ADDR-1:0]            take_b,
    input  rf_pkg::word_t                            wr_a_data,
    input  rf_pkg::word_t                            wr_b_data,
    output rf_pkg::word_t [rf_pkg::FLAGS_ADDR-1:0]   regs_gp
);

    import rf_pkg::*;

    // Registers 0 to 21, CPU write ports only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs_gp <= '0;
        end else begin
            for (int i = 0; i < FLAGS_ADDR; i++) begin
                if (cpu_we[i]) begin
                    // Port A unless the decoder handed this one to port B
                    regs_gp[i] <= take_b[i] ? wr_b_data : wr_a_data;
                end
            end
        end
    end

endmodule

//--- flags_reg.sv
`timescale 1ns/1ps

module flags_reg (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cpu_we_flags,
    input  logic                          take_b_flags,
    input  rf_pkg::word_t                 wr_a_data,
    input  rf_pkg::word_t                 wr_b_data,
    input  logic                          flags_we,
    input  rf_pkg::cpu_flags_t            flags,
    input  logic                          keys_we,
    input  logic [rf_pkg::NUM_KEYS-1:0]   keys,
    output rf_pkg::word_t                 flags_word
);

    import rf_pkg::*;

    flags_word_u flags_q;
    flags_word_u flags_d;

    ////////////////////////////////////////////////////////////
    // Next-value select
    ////////////////////////////////////////////////////////////
    always_comb begin
        flags_d = flags_q;
        if (flags_we) begin
            // ALU result bits only, general byte and keys untouched
            flags_d.fields.z = flags.z;
            flags_d.fields.n = flags.n;
            flags_d.fields.v = flags.v;
        end else if (keys_we) begin
            // Sticky key presses
            flags_d.fields.keys = flags_q.fields.keys | keys;
        end else if (cpu_we_flags) begin
            // Whole word from the CPU, port A ahead of port B
            flags_d.raw = take_b_flags ? wr_b_data : wr_a_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags_q.raw <= '0;
        end else begin
            flags_q <= flags_d;
        end
    end

    assign flags_word = flags_q.raw;

endmodule

//--- vpu_reg_bank.sv
`timescale 1ns/1ps

module vpu_reg_bank (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [rf_pkg::NUM_VPU_REGS-1:0]   cpu_we_vpu,
    input  logic [rf_pkg::NUM_VPU_REGS-1:0]   take_b_vpu,
    input  rf_pkg::word_t                     wr_a_data,
    input  rf_pkg::word_t                     wr_b_data,
    input  rf_pkg::vpu_wr_t                   vpu_wr,
    output rf_pkg::vpu_rd_t                   vpu_rd
);

    import rf_pkg::*;

    // Index 0 is the return object, 1 to 8 are the vertices,
    // so index i sits at address RO_ADDR + i
    word_t [NUM_VPU_REGS-1:0] vpu_data;
    word_t [NUM_VPU_REGS-1:0] regs_q;

    assign vpu_data = {vpu_wr.vertex, vpu_wr.ret_obj};

    ////////////////////////////////////////////////////////////
    // Storage with VPU priority
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs_q <= '0;
        end else begin
            for (int i = 0; i < NUM_VPU_REGS; i++) begin
                if (vpu_wr.we) begin
                    regs_q[i] <= vpu_data[i];
                end else if (cpu_we_vpu[i]) begin
                    regs_q[i] <= take_b_vpu[i] ? wr_b_data : wr_a_data;
                end
            end
        end
    end

    // VPU sees all nine words at all times
    assign vpu_rd = '{ret_obj: regs_q[0], vertex: regs_q[NUM_VPU_REGS-1:1]};

endmodule

//--- read_mux.sv
`timescale 1ns/1ps

module read_mux (
    input  rf_pkg::word_t [rf_pkg::NUM_REGS-1:0]  regs,
    input  rf_pkg::addr_t                         rd_addr_0,
    input  rf_pkg::addr_t                         rd_addr_1,
    output rf_pkg::word_t                         rd_data_0,
    output rf_pkg::word_t                         rd_data_1
);

    import rf_pkg::*;

    // Two independent selectors over all 32 words
    always_comb begin
        rd_data_0 = regs[rd_addr_0];
    end

    always_comb begin
        rd_data_1 = regs[rd_addr_1];
    end

endmodule

//--- register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                          clk,
    input  logic                          rst_n,
    // CPU write ports
    input  rf_pkg::cpu_wr_t               wr_a,
    input  rf_pkg::cpu_wr_t               wr_b,
    // Flag and key updates
    input  logic                          flags_we,
    input  rf_pkg::cpu_flags_t            flags,
    input  logic                          keys_we,
    input  logic [rf_pkg::NUM_KEYS-1:0]   keys,
    // VPU side
    input  rf_pkg::vpu_wr_t               vpu_wr,
    output rf_pkg::vpu_rd_t               vpu_rd,
    // CPU read ports
    input  rf_pkg::addr_t                 rd_addr_0,
    input  rf_pkg::addr_t                 rd_addr_1,
    output rf_pkg::word_t                 rd_data_0,
    output rf_pkg::word_t                 rd_data_1
);

    import rf_pkg::*;

    reg_vec_t                  cpu_we;
    reg_vec_t                  take_b;
    word_t [FLAGS_ADDR-1:0]    regs_gp;
    word_t                     flags_word;
    wire word_t [NUM_REGS-1:0] regs;

    ////////////////////////////////////////////////////////////
    // Write decode
    ////////////////////////////////////////////////////////////
    cpu_write_decode u_decode (
        .wr_a   (wr_a),
        .wr_b   (wr_b),
        .cpu_we (cpu_we),
        .take_b (take_b)
    );

    ////////////////////////////////////////////////////////////
    // Register banks
    ////////////////////////////////////////////////////////////
    // General registers 0 to 21
    gp_reg_bank u_gp_bank (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_we    (cpu_we[FLAGS_ADDR-1:0]),
        .take_b    (take_b[FLAGS_ADDR-1:0]),
        .wr_a_data (wr_a.data),
        .wr_b_data (wr_b.data),
        .regs_gp   (regs_gp)
    );

    flags_reg u_flags (
        .clk          (clk),
        .rst_n        (rst_n),
        .cpu_we_flags (cpu_we[FLAGS_ADDR]),
        .take_b_flags (take_b[FLAGS_ADDR]),
        .wr_a_data    (wr_a.data),
        .wr_b_data    (wr_b.data),
        .flags_we     (flags_we),
        .flags        (flags),
        .keys_we      (keys_we),
        .keys         (keys),
        .flags_word   (flags_word)
    );

    // Return object and vertices, 23 to 31
    vpu_reg_bank u_vpu_bank (
        .clk        (clk),
        .rst_n      (rst_n),
        .cpu_we_vpu (cpu_we[NUM_REGS-1:RO_ADDR]),
        .take_b_vpu (take_b[NUM_REGS-1:RO_ADDR]),
        .wr_a_data  (wr_a.data),
        .wr_b_data  (wr_b.data),
        .vpu_wr     (vpu_wr),
        .vpu_rd     (vpu_rd)
    );

    ////////////////////////////////////////////////////////////
    // Read path
    ////////////////////////////////////////////////////////////
    assign regs[FLAGS_ADDR-1:0]           = regs_gp;
    assign regs[FLAGS_ADDR]               = flags_word;
    assign regs[RO_ADDR]                  = vpu_rd.ret_obj;
    assign regs[NUM_REGS-1:VERTEX_BASE]   = vpu_rd.vertex;

    read_mux u_read_mux (
        .regs      (regs),
        .rd_addr_0 (rd_addr_0),
        .rd_addr_1 (rd_addr_1),
        .rd_data_0 (rd_data_0),
        .rd_data_1 (rd_data_1)
    );

endmodule

//--- tb_stimulus.svh
`ifndef TB_STIMULUS_SVH
`define TB_STIMULUS_SVH

////////////////////////////////////////////////////////////
// Random numbers
////////////////////////////////////////////////////////////
// 32-bit LCG with the usual multiplier and increment
function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

function automatic word_t rand_word();
    logic [31:0] r;
    r = lcg_next();
    return r[31:16];
endfunction

function automatic addr_t rand_addr();
    logic [31:0] r;
    r = lcg_next();
    return r[31:27];
endfunction

function automatic cpu_wr_t make_wr(input logic we, input addr_t addr, input word_t data);
    cpu_wr_t w;
    w.we   = we;
    w.addr = addr;
    w.data = data;
    return w;
endfunction

////////////////////////////////////////////////////////////
// Input drivers, all on the falling edge
////////////////////////////////////////////////////////////
task automatic init_inputs();
    rst_n     = 1'b0;
    wr_a      = '0;
    wr_b      = '0;
    flags_we  = 1'b0;
    flags     = '0;
    keys_we   = 1'b0;
    keys      = '0;
    vpu_wr    = '0;
    rd_addr_0 = '0;
    rd_addr_1 = '0;
endtask

// Every strobe lasts one cycle unless driven again
task automatic clear_strobes();
    wr_a.we   = 1'b0;
    wr_b.we   = 1'b0;
    flags_we  = 1'b0;
    keys_we   = 1'b0;
    vpu_wr.we = 1'b0;
endtask

task automatic drive_cycle(input cpu_wr_t a, input cpu_wr_t b, input addr_t r0, input addr_t r1);
    @(negedge clk);
    clear_strobes();
    wr_a      = a;
    wr_b      = b;
    rd_addr_0 = r0;
    rd_addr_1 = r1;
endtask

// Read addresses stay where they are
task automatic drive_flag_cycle(input logic f_we, input cpu_flags_t f, input logic k_we,
                                input logic [NUM_KEYS-1:0] k, input cpu_wr_t a,
                                input cpu_wr_t b);
    @(negedge clk);
    clear_strobes();
    flags_we = f_we;
    flags    = f;
    keys_we  = k_we;
    keys     = k;
    wr_a     = a;
    wr_b     = b;
endtask

task automatic drive_vpu_cycle(input vpu_wr_t v, input cpu_wr_t a, input cpu_wr_t b,
                               input addr_t r0, input addr_t r1);
    @(negedge clk);
    clear_strobes();
    vpu_wr    = v;
    wr_a      = a;
    wr_b      = b;
    rd_addr_0 = r0;
    rd_addr_1 = r1;
endtask

`endif

//--- tb_register_file.sv
`timescale 1ns/1ps

module tb_register_file;

    import rf_pkg::*;

    localparam int CLK_PERIOD      = 100;
    localparam int RANDOM_CYCLES   = 200;
    // Reset, sweeps and directed sequences add up to under this
    localparam int TEST_CYCLES     = 300;
    localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES;
    localparam int VPU_RD_W        = $bits(vpu_rd_t);

    logic                clk = 1'b0;
    logic                rst_n;
    cpu_wr_t             wr_a;
    cpu_wr_t             wr_b;
    logic                flags_we;
    cpu_flags_t          flags;
    logic                keys_we;
    logic [NUM_KEYS-1:0] keys;
    vpu_wr_t             vpu_wr;
    vpu_rd_t             vpu_rd;
    addr_t               rd_addr_0;
    addr_t               rd_addr_1;
    word_t               rd_data_0;
    word_t               rd_data_1;

    logic [31:0]         lcg_state = 32'hca8b_b5c0;

    // Reference model and the values it predicts
    word_t               model [NUM_REGS];
    word_t               next_model [NUM_REGS];
    word_t               flags_next;
    word_t               exp_rd_0;
    word_t               exp_rd_1;
    vpu_rd_t             exp_vpu_rd;

    `include "tb_stimulus.svh"

    always #(CLK_PERIOD / 2) clk = ~clk;

    register_file dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_a      (wr_a),
        .wr_b      (wr_b),
        .flags_we  (flags_we),
        .flags     (flags),
        .keys_we   (keys_we),
        .keys      (keys),
        .vpu_wr    (vpu_wr),
        .vpu_rd    (vpu_rd),
        .rd_addr_0 (rd_addr_0),
        .rd_addr_1 (rd_addr_1),
        .rd_data_0 (rd_data_0),
        .rd_data_1 (rd_data_1)
    );

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                model[i] <= '0;
            end
        end else begin
            next_model = model;
            // Port B first so that port A overwrites on a collision
            if (wr_b.we) begin
                next_model[wr_b.addr] = wr_b.data;
            end
            if (wr_a.we) begin
                next_model[wr_a.addr] = wr_a.data;
            end
            // Keys sit in bits 7:3 of the flags word and z n v in bits 2:0
            flags_next = model[FLAGS_ADDR];
            if (flags_we) begin
                flags_next[2:0] = {flags.z, flags.n, flags.v};
                next_model[FLAGS_ADDR] = flags_next;
            end else if (keys_we) begin
                flags_next[7:3] = flags_next[7:3] | keys;
                next_model[FLAGS_ADDR] = flags_next;
            end
            // VPU bulk write beats both CPU ports
            if (vpu_wr.we) begin
                next_model[RO_ADDR] = vpu_wr.ret_obj;
                for (int v = 0; v < NUM_VERTEX; v++) begin
                    next_model[VERTEX_BASE + v] = vpu_wr.vertex[v];
                end
            end
            model <= next_model;
        end
    end

    assign exp_rd_0 = model[rd_addr_0];
    assign exp_rd_1 = model[rd_addr_1];

    always_comb begin
        exp_vpu_rd.ret_obj = model[RO_ADDR];
        for (int v = 0; v < NUM_VERTEX; v++) begin
            exp_vpu_rd.vertex[v] = model[VERTEX_BASE + v];
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////
    task automatic report_mismatch(input string name, input logic [VPU_RD_W-1:0] got,
                                   input logic [VPU_RD_W-1:0] exp);
        $display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        $display("Errors found");
        $fatal(1);
    endtask

    rd_data_0_check: assert property (@(posedge clk) disable iff (!rst_n)
        rd_data_0 == exp_rd_0)
        else report_mismatch("rd_data_0", VPU_RD_W'($sampled(rd_data_0)),
                             VPU_RD_W'($sampled(exp_rd_0)));

    rd_data_1_check: assert property (@(posedge clk) disable iff (!rst_n)
        rd_data_1 == exp_rd_1)
        else report_mismatch("rd_data_1", VPU_RD_W'($sampled(rd_data_1)),
                             VPU_RD_W'($sampled(exp_rd_1)));

    vpu_rd_check: assert property (@(posedge clk) disable iff (!rst_n)
        vpu_rd == exp_vpu_rd)
        else report_mismatch("vpu_rd", $sampled(vpu_rd), $sampled(exp_vpu_rd));

    ////////////////////////////////////////////////////////////
    // Test sequences
    ////////////////////////////////////////////////////////////
    // Port 1 walks the range backwards
    task automatic read_range(input int lo, input int hi);
        for (int a = lo; a <= hi; a++) begin
            drive_cycle(make_wr(1'b0, '0, '0), make_wr(1'b0, '0, '0), addr_t'(a),
                        addr_t'(hi + lo - a));
        end
    endtask

    // One port reads the register being written, the other the previous target
    task automatic random_pair_writes();
        addr_t a_addr;
        addr_t b_addr;
        addr_t prev_a;
        addr_t prev_b;
        prev_a = '0;
        prev_b = '0;
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            a_addr = rand_addr();
            b_addr = rand_addr();
            if (b_addr == a_addr) begin
                b_addr = a_addr + 5'd1;
            end
            if (i % 2 == 0) begin
                drive_cycle(make_wr(1'b1, a_addr, rand_word()),
                            make_wr(1'b1, b_addr, rand_word()), a_addr, prev_b);
            end else begin
                drive_cycle(make_wr(1'b1, a_addr, rand_word()),
                            make_wr(1'b1, b_addr, rand_word()), prev_a, b_addr);
            end
            prev_a = a_addr;
            prev_b = b_addr;
        end
    endtask

    task automatic same_address_writes();
        addr_t addr;
        addr_t prev;
        prev = '0;
        for (int i = 0; i < 8; i++) begin
            addr = (i == 0) ? addr_t'(FLAGS_ADDR) : rand_addr();
            drive_cycle(make_wr(1'b1, addr, rand_word()), make_wr(1'b1, addr, rand_word()),
                        prev, addr);
            prev = addr;
        end
    endtask

    task automatic flag_key_updates();
        // General byte set first so that it can be seen to survive
        drive_cycle(make_wr(1'b1, addr_t'(FLAGS_ADDR), 16'h5a00), make_wr(1'b0, '0, '0),
                    addr_t'(FLAGS_ADDR), addr_t'(FLAGS_ADDR));
        drive_flag_cycle(1'b1, cpu_flags_t'(3'b101), 1'b0, 5'b00000,
                         make_wr(1'b0, '0, '0), make_wr(1'b0, '0, '0));
        drive_flag_cycle(1'b0, cpu_flags_t'(3'b000), 1'b1, 5'b01001,
                         make_wr(1'b0, '0, '0), make_wr(1'b0, '0, '0));
        drive_flag_cycle(1'b0, cpu_flags_t'(3'b000), 1'b1, 5'b00110,
                         make_wr(1'b0, '0, '0), make_wr(1'b0, '0, '0));
        // All four sources at once
        drive_flag_cycle(1'b1, cpu_flags_t'(3'b010), 1'b1, 5'b10000,
                         make_wr(1'b1, addr_t'(FLAGS_ADDR), 16'hffff),
                         make_wr(1'b1, addr_t'(FLAGS_ADDR), 16'h1234));
        read_range(FLAGS_ADDR, FLAGS_ADDR);
    endtask

    task automatic vpu_priority_writes();
        vpu_wr_t vw;
        vw.we      = 1'b1;
        vw.ret_obj = rand_word();
        for (int v = 0; v < NUM_VERTEX; v++) begin
            vw.vertex[v] = rand_word();
        end
        drive_vpu_cycle(vw, make_wr(1'b1, addr_t'(RO_ADDR), rand_word()),
                        make_wr(1'b1, addr_t'(30), rand_word()), addr_t'(RO_ADDR), addr_t'(30));
        read_range(RO_ADDR, NUM_REGS - 1);
    endtask

    task automatic cpu_vpu_register_writes();
        for (int i = 0; i < NUM_VPU_REGS; i++) begin
            drive_cycle(make_wr(1'b1, addr_t'(RO_ADDR + i), rand_word()),
                        make_wr(1'b1, addr_t'(NUM_REGS - 1 - i), rand_word()),
                        addr_t'(RO_ADDR + i), addr_t'(NUM_REGS - 1 - i));
        end
        read_range(RO_ADDR, NUM_REGS - 1);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////////////////////////
    initial begin
        init_inputs();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        read_range(0, NUM_REGS - 1);
        random_pair_writes();
        same_address_writes();
        flag_key_updates();
        vpu_priority_writes();
        cpu_vpu_register_writes();
        drive_cycle(make_wr(1'b0, '0, '0), make_wr(1'b0, '0, '0), '0, '0);
        // Let the last edges be checked
        repeat (2) @(posedge clk);
        $display("No errors");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the test did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Errors found");
        $fatal(1);
    end

endmodule

//--- project.f
+incdir+.
rf_pkg.sv
cpu_write_decode.sv
gp_reg_bank.sv
flags_reg.sv
vpu_reg_bank.sv
read_mux.sv
register_file.sv
tb_register_file.sv

//--- Makefile
# Verilator build and run for the register file testbench

VERILATOR ?= verilator
TOP       ?= tb_register_file
FILE_LIST ?= project.f
BUILD_DIR ?= obj_dir
HEADERS   ?= tb_stimulus.svh
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= No errors

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

# Passes only when the pass message is printed
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
